// File: Makefile
TOOL       = verilator
TOP        = tb_fb_box_top
FLIST      = flist.f
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS  = --binary --timing --assert -Wno-fatal
BUILD_DIR  = obj_dir
LOG        = sim.log
FAIL_MSG   = TEST RESULT: FAIL

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(TOOL) $(SIM_FLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: flist.f
hw/fb_pkg.sv
hw/bram_sdp.sv
hw/display_timings.sv
hw/box_drawer.sv
hw/framebuffer_scanout.sv
hw/fb_box_top.sv
sim/tb_fb_box_top.sv

// File: hw/box_drawer.sv
// ####################
// FSM drawing a one-pixel border box into the framebuffer,
// once after reset
// ####################

`timescale 1ns/100ps

module box_drawer
    import fb_pkg::*;
(
    input  logic      clk_pix,
    input  logic      reset,
    input  timing_t   timing,
    output fb_write_t fb_write
);

    draw_state_t                 state;
    logic [$clog2(FB_WIDTH)-1:0] cnt_draw;  // pixels done on current edge

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            state       <= IDLE;
            cnt_draw    <= '0;
            fb_write.we <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (timing.frame) begin  // start of vertical blanking
                        fb_write.we   <= 1'b1;
                        fb_write.addr <= '0;
                        fb_write.colr <= FB_DATAW'(1);
                        cnt_draw      <= '0;
                        state         <= TOP;
                    end
                end
                TOP: begin
                    if (cnt_draw < FB_WIDTH - 1) begin
                        fb_write.addr <= fb_write.addr + 1'b1;
                        cnt_draw      <= cnt_draw + 1'b1;
                    end else begin
                        cnt_draw <= '0;
                        state    <= RIGHT;  // carries on down from top-right corner
                    end
                end
                RIGHT: begin
                    if (cnt_draw < FB_HEIGHT - 1) begin
                        fb_write.addr <= fb_write.addr + FB_ADDRW'(FB_WIDTH);
                        cnt_draw      <= cnt_draw + 1'b1;
                    end else begin
                        fb_write.addr <= '0;  // back to top-left corner
                        cnt_draw      <= '0;
                        state         <= LEFT;
                    end
                end
                LEFT: begin
                    if (cnt_draw < FB_HEIGHT - 1) begin
                        fb_write.addr <= fb_write.addr + FB_ADDRW'(FB_WIDTH);
                        cnt_draw      <= cnt_draw + 1'b1;
                    end else begin
                        cnt_draw <= '0;
                        state    <= BOTTOM;
                    end
                end
                BOTTOM: begin
                    if (cnt_draw < FB_WIDTH - 1) begin
                        fb_write.addr <= fb_write.addr + 1'b1;
                        cnt_draw      <= cnt_draw + 1'b1;
                    end else begin
                        fb_write.we <= 1'b0;  // last pixel written this cycle
                        state       <= DONE;
                    end
                end
                default: state <= DONE;  // parked until next reset
            endcase
        end
    end

    // the edge walk must never leave the framebuffer
    write_addr_in_range: assert property (
        @(posedge clk_pix) disable iff (reset)
        fb_write.we |-> (fb_write.addr < FB_ADDRW'(FB_PIXELS))
    );

endmodule

// File: hw/bram_sdp.sv
// ####################
// simple dual-port memory, one write and one registered read
// ####################

`timescale 1ns/100ps

module bram_sdp #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 256
) (
    input  logic                     clk_pix,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] addr_write,
    input  logic [$clog2(DEPTH)-1:0] addr_read,
    input  logic [WIDTH-1:0]         data_in,
    output logic [WIDTH-1:0]         data_out
);

    logic [WIDTH-1:0] memory [DEPTH];

    // contents start cleared
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            memory[i] = '0;
        end
    end

    always_ff @(posedge clk_pix) begin
        if (we) begin
            memory[addr_write] <= data_in;
        end
        data_out <= memory[addr_read];  // one cycle read latency
    end

endmodule

// File: hw/display_timings.sv
// ####################
// 640x480 raster counters with sync, enable
// and end-of-frame strobe
// ####################

`timescale 1ns/100ps

module display_timings
    import fb_pkg::*;
(
    input  logic    clk_pix,
    input  logic    reset,
    output timing_t timing
);

    logic [CORDW-1:0] sx;
    logic [CORDW-1:0] sy;
    logic             line_end;
    logic             frame_end;

    assign line_end  = (sx == CORDW'(H_TOTAL - 1));
    assign frame_end = (sy == CORDW'(V_TOTAL - 1));

    // horizontal counter runs every cycle, vertical steps at line end
    always_ff @(posedge clk_pix) begin
        if (reset) begin
            sx <= '0;
            sy <= '0;
        end else if (line_end) begin
            sx <= '0;
            if (frame_end) begin
                sy <= '0;
            end else begin
                sy <= sy + 1'b1;
            end
        end else begin
            sx <= sx + 1'b1;
        end
    end

    // everything below decodes straight from the counter registers
    always_comb begin
        timing.sx    = sx;
        timing.sy    = sy;
        timing.hsync = ~(sx >= CORDW'(HS_START) && sx < CORDW'(HS_END));  // active low
        timing.vsync = ~(sy >= CORDW'(VS_START) && sy < CORDW'(VS_END));
        timing.de    = (sx < CORDW'(H_ACTIVE)) && (sy < CORDW'(V_ACTIVE));
        // one cycle at (0, 480), start of vertical blanking
        timing.frame = (sx == '0) && (sy == CORDW'(V_ACTIVE));
    end

endmodule

// File: hw/fb_box_top.sv
// ####################
// top level: raster timing, box drawer
// and framebuffer scanout
// ####################

`timescale 1ns/100ps

module fb_box_top
    import fb_pkg::*;
(
    input  logic   clk_pix,
    input  logic   reset,
    output video_t video  // two cycles behind the raster coordinate
);

    timing_t   timing;
    fb_write_t fb_write;

    display_timings display_timings_inst (
        .clk_pix (clk_pix),
        .reset   (reset),
        .timing  (timing)
    );

    // only the frame strobe is used here
    box_drawer box_drawer_inst (
        .clk_pix  (clk_pix),
        .reset    (reset),
        .timing   (timing),
        .fb_write (fb_write)
    );

    framebuffer_scanout framebuffer_scanout_inst (
        .clk_pix  (clk_pix),
        .reset    (reset),
        .timing   (timing),
        .fb_write (fb_write),
        .video    (video)
    );

endmodule

// File: hw/fb_pkg.sv
// ####################
// shared raster and framebuffer constants, bus structs
// and the draw FSM state type
// ####################

package fb_pkg;

    // 640x480 at 60 Hz, syncs active low
    localparam int H_ACTIVE = 640;
    localparam int H_FRONT  = 16;
    localparam int H_SYNC   = 96;
    localparam int H_BACK   = 48;
    localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;  // 800

    localparam int V_ACTIVE = 480;
    localparam int V_FRONT  = 10;
    localparam int V_SYNC   = 2;
    localparam int V_BACK   = 33;
    localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;  // 525

    // sync pulse windows, end is exclusive
    localparam int HS_START = H_ACTIVE + H_FRONT;
    localparam int HS_END   = HS_START + H_SYNC;
    localparam int VS_START = V_ACTIVE + V_FRONT;
    localparam int VS_END   = VS_START + V_SYNC;

    localparam int CORDW = 10;  // screen coordinate width

    // 1-bit framebuffer in the top-left corner
    localparam int FB_WIDTH  = 160;
    localparam int FB_HEIGHT = 120;
    localparam int FB_PIXELS = FB_WIDTH * FB_HEIGHT;  // 19200
    localparam int FB_ADDRW  = $clog2(FB_PIXELS);     // 15
    localparam int FB_DATAW  = 1;

    localparam logic [7:0] COLR_ON  = 8'hFF;
    localparam logic [7:0] COLR_OFF = 8'h00;

    typedef struct packed {
        logic [CORDW-1:0] sx;
        logic [CORDW-1:0] sy;
        logic             hsync;
        logic             vsync;
        logic             de;     // active area
        logic             frame;  // first cycle after last active line
    } timing_t;

    typedef struct packed {
        logic                we;
        logic [FB_ADDRW-1:0] addr;
        logic [FB_DATAW-1:0] colr;
    } fb_write_t;

    typedef struct packed {
        logic       hsync;
        logic       vsync;
        logic       de;
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } video_t;

    typedef enum logic [2:0] {IDLE, TOP, RIGHT, LEFT, BOTTOM, DONE} draw_state_t;

endpackage

// File: hw/framebuffer_scanout.sv
// ####################
// framebuffer memory, raster-order read address,
// timing delay and output colour register
// ####################

`timescale 1ns/100ps

module framebuffer_scanout
    import fb_pkg::*;
(
    input  logic      clk_pix,
    input  logic      reset,
    input  timing_t   timing,
    input  fb_write_t fb_write,
    output video_t    video
);

    logic                paint;
    logic [FB_ADDRW-1:0] addr_read;
    logic [FB_DATAW-1:0] colr_read;
    logic                paint_p1;
    logic                hsync_p1;
    logic                vsync_p1;
    logic                de_p1;
    logic                lit;

    bram_sdp #(
        .WIDTH (FB_DATAW),
        .DEPTH (FB_PIXELS)
    ) bram_inst (
        .clk_pix    (clk_pix),
        .we         (fb_write.we),
        .addr_write (fb_write.addr),
        .addr_read  (addr_read),
        .data_in    (fb_write.colr),
        .data_out   (colr_read)
    );

    // framebuffer covers the top-left 160x120 of the raster
    assign paint = (timing.sx < CORDW'(FB_WIDTH)) && (timing.sy < CORDW'(FB_HEIGHT));

    // parks one past the last pixel until the next frame strobe
    always_ff @(posedge clk_pix) begin
        if (reset || timing.frame) begin
            addr_read <= '0;
        end else if (paint) begin
            addr_read <= addr_read + 1'b1;
        end
    end

    // match the one cycle memory read
    always_ff @(posedge clk_pix) begin
        if (reset) begin
            paint_p1 <= 1'b0;
            hsync_p1 <= 1'b1;
            vsync_p1 <= 1'b1;
            de_p1    <= 1'b0;
        end else begin
            paint_p1 <= paint;
            hsync_p1 <= timing.hsync;
            vsync_p1 <= timing.vsync;
            de_p1    <= timing.de;
        end
    end

    assign lit = paint_p1 && (colr_read != '0);

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            video <= '{hsync: 1'b1, vsync: 1'b1, de: 1'b0,
                       red: COLR_OFF, green: COLR_OFF, blue: COLR_OFF};
        end else begin
            video.hsync <= hsync_p1;
            video.vsync <= vsync_p1;
            video.de    <= de_p1;
            video.red   <= lit ? COLR_ON : COLR_OFF;  // white on black
            video.green <= lit ? COLR_ON : COLR_OFF;
            video.blue  <= lit ? COLR_ON : COLR_OFF;
        end
    end

    // address in use while painting stays inside the framebuffer
    read_addr_in_range: assert property (
        @(posedge clk_pix) disable iff (reset)
        paint |-> (addr_read < FB_ADDRW'(FB_PIXELS))
    );

endmodule

// File: sim/fb_box_patterns.txt
// frame x y lit, all hex, one sample point per line
// sorted by frame, then y, then x, as the raster scans them
0 000 000 0
0 0c8 00a 0
0 050 03c 0
0 09f 077 0
0 005 12c 0
0 27f 1df 0
1 000 000 1
1 050 000 1
1 09f 000 1
1 0a0 000 0
1 0c8 00a 0
1 000 03c 1
1 050 03c 0
1 09f 03c 1
1 000 077 1
1 050 077 1
1 09f 077 1
1 000 078 0
1 005 12c 0
2 000 000 1
2 050 000 1
2 09f 000 1
2 0a0 000 0
2 0c8 00a 0
2 000 03c 1
2 050 03c 0
2 09f 03c 1
2 000 077 1
2 050 077 1
2 09f 077 1
2 000 078 0
2 005 12c 0

// File: sim/tb_fb_box_top.sv
// ####################
// testbench for fb_box_top: raster geometry, reset state
// and sampled pixels against the pattern file
// ####################

`timescale 1ns/100ps

module tb_fb_box_top
    import fb_pkg::*;
;

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 5;
    localparam int N_FRAMES     = 3;
    localparam int MAX_POINTS   = 64;
    // three full frames of cycles plus 10% margin
    localparam int WATCHDOG_NS  = N_FRAMES * H_TOTAL * V_TOTAL * CLK_PERIOD * 11 / 10;

    logic   clk_pix;
    logic   reset;
    video_t video;

    // pattern records, four words each: frame, x, y, lit
    logic [11:0] pat_mem [4*MAX_POINTS];
    int          n_points;
    int          pat_idx;

    int mismatches;
    int failures;

    // position rebuilt from the video port only
    video_t video_q;
    int     x_cnt;
    int     y_cnt;
    int     frame_cnt;  // frame 0 is the first after reset
    int     hs_len;
    int     vs_len;
    logic   rst_d1;
    logic   rst_d2;

    fb_box_top uut (
        .clk_pix (clk_pix),
        .reset   (reset),
        .video   (video)
    );

    always #(CLK_PERIOD / 2) clk_pix = ~clk_pix;

    task automatic check_value(input string name, input logic [31:0] observed,
                               input logic [31:0] expected);
        if (observed !== expected) begin
            mismatches++;
            $display("MISMATCH at %0t ns: %s observed %0h expected %0h",
                     $time, name, observed, expected);
        end
    endtask

    task automatic report_failure(input string msg);
        failures++;
        $display("ERROR at %0t ns: %s", $time, msg);
    endtask

    task automatic check_reset_state();
        check_value("video.de", 32'(video.de), 0);
        check_value("video.hsync", 32'(video.hsync), 1);
        check_value("video.vsync", 32'(video.vsync), 1);
        check_value("video colour", 32'({video.red, video.green, video.blue}), 0);
    endtask

    // compares the current pixel with the next pattern record, if it is this one
    // frame 2 records repeat frame 1, so a second draw or a stale address shows up
    task automatic check_sample_point(input int x, input int y);
        int    base;
        int    exp_colr;
        string where;
        base = 4 * pat_idx;
        if (pat_idx < n_points && int'(pat_mem[base]) == frame_cnt &&
            int'(pat_mem[base + 1]) == x && int'(pat_mem[base + 2]) == y) begin
            exp_colr = (pat_mem[base + 3] != 0) ? 255 : 0;
            where    = $sformatf("frame %0d (%0d,%0d)", frame_cnt, x, y);
            check_value({"video.red at ", where}, 32'(video.red), exp_colr);
            check_value({"video.green at ", where}, 32'(video.green), exp_colr);
            check_value({"video.blue at ", where}, 32'(video.blue), exp_colr);
            pat_idx++;
        end
    endtask

    // output monitor, sampled on the rising edge
    always @(posedge clk_pix) begin
        rst_d1 <= reset;
        rst_d2 <= rst_d1;
        if (rst_d1 || rst_d2) begin
            check_reset_state();  // pipeline still holds reset values
        end else if (!reset) begin
            if (video.de) begin
                if (frame_cnt == 0) begin  // nothing drawn yet
                    check_value("video colour in frame 0",
                                32'({video.red, video.green, video.blue}), 0);
                end
                check_sample_point(x_cnt, y_cnt);
                x_cnt++;
            end
            if (video_q.de && !video.de) begin  // end of an active line
                check_value("de cycles per line", x_cnt, H_ACTIVE);
                x_cnt = 0;
                y_cnt++;
            end

            if (!video.hsync) begin
                hs_len++;
            end
            if (!video_q.hsync && video.hsync) begin
                check_value("hsync pulse cycles", hs_len, H_SYNC);
                hs_len = 0;
            end

            if (!video.vsync) begin
                vs_len++;
            end
            if (!video_q.vsync && video.vsync) begin
                check_value("vsync pulse cycles", vs_len, V_SYNC * H_TOTAL);
                vs_len = 0;
            end
            if (video_q.vsync && !video.vsync) begin  // vsync start closes a frame
                check_value("active lines per frame", y_cnt, V_ACTIVE);
                y_cnt = 0;
                frame_cnt++;
            end
            video_q = video;
        end
    end

    initial begin
        clk_pix    = 1'b0;
        reset      = 1'b1;
        mismatches = 0;
        failures   = 0;
        pat_idx    = 0;
        x_cnt      = 0;
        y_cnt      = 0;
        frame_cnt  = 0;
        hs_len     = 0;
        vs_len     = 0;
        rst_d1     = 1'b0;
        rst_d2     = 1'b0;
        video_q    = '{hsync: 1'b1, vsync: 1'b1, de: 1'b0, red: 8'h00, green: 8'h00,
                       blue: 8'h00};

        for (int i = 0; i < 4 * MAX_POINTS; i++) begin
            pat_mem[i] = 12'hfff;  // end marker
        end
        $readmemh("sim/fb_box_patterns.txt", pat_mem);
        n_points = 0;
        while (n_points < MAX_POINTS && pat_mem[4 * n_points] !== 12'hfff) begin
            n_points++;
        end
        if (n_points == 0) begin
            report_failure("no sample points could be read from the pattern file");
        end

        repeat (RESET_CYCLES) @(posedge clk_pix);
        reset <= 1'b0;

        wait (frame_cnt == N_FRAMES);
        @(posedge clk_pix);
        if (pat_idx != n_points) begin
            report_failure($sformatf("only %0d of %0d sample points were reached",
                                     pat_idx, n_points));
        end
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("ERROR: watchdog expired after %0d ns, the video output stopped advancing",
                 WATCHDOG_NS);
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures + 1);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule
